// File: src.f
logic/mempool_l2_pkg.sv
logic/l2_req_xbar.sv
logic/l2_bank.sv
logic/l2_rsp_router.sv
logic/mempool_l2.sv
testbench/tb_clkgen.sv
testbench/mempool_l2_asserts.sv
testbench/tb_mempool_l2.sv

// File: testbench/tb_mempool_l2.sv
/* Testbench for the banked L2 memory
   Directed bank 0 contention, then LFSR-driven four-phase requesters on every port */

`timescale 1ns/1ps

module tb_mempool_l2;

  localparam int unsigned NumPorts      = 4;
  localparam int unsigned NumRandom     = 60;
  localparam int unsigned TimeoutCycles = 64 * NumPorts * (3 + NumPorts + 4) + 200;

  logic                                               clk;
  logic                                               arst_n;
  logic                    [NumPorts-1:0]             req;
  mempool_l2_pkg::l2_req_t [NumPorts-1:0]             req_data;
  logic                    [NumPorts-1:0]             ack;
  logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0] rdata;

  logic [15:0]         lfsr_q [NumPorts];
  logic [NumPorts-1:0] dir_done  = '0;
  logic [NumPorts-1:0] port_done = '0;
  int                  cycle_cnt;

  tb_clkgen i_clkgen (
    .clk_o (clk)
  );

  mempool_l2 #(
    .NumPorts (NumPorts)
  ) u_dut (
    .clk_i      (clk     ),
    .arst_n_i   (arst_n  ),
    .req_i      (req     ),
    .req_data_i (req_data),
    .ack_o      (ack     ),
    .rdata_o    (rdata   )
  );

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int p, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q[p] = lfsr_next(lfsr_q[p]);
      v = {v[30:0], lfsr_q[p][0]};
    end
  endtask

  function automatic mempool_l2_pkg::l2_req_t make_req(input logic we, input logic [1:0] bank,
      input logic [1:0] row, input logic [1:0] byte_off, input logic [1:0] alias_hi,
      input logic [31:0] wdata, input logic [3:0] strb);
    mempool_l2_pkg::l2_req_t rq;
    rq = '0;
    rq.addr.fields.unused[1:0] = alias_hi;   // Steps of L2SizeBytes
    rq.addr.fields.row[1:0]    = row;
    rq.addr.fields.bank        = bank;
    rq.addr.fields.byte_off    = byte_off;
    rq.we    = we;
    rq.wdata = wdata;
    rq.strb  = strb;
    return rq;
  endfunction

  // One full four-phase handshake, entered and left on a rising edge
  task automatic run_access(input int p, input mempool_l2_pkg::l2_req_t rq);
    req_data[p] <= rq;
    req[p]      <= 1'b1;
    @(posedge clk);
    while (!ack[p]) begin
      @(posedge clk);
    end
    req[p] <= 1'b0;
    @(posedge clk);
    while (ack[p]) begin
      @(posedge clk);
    end
  endtask

  for (genvar p = 0; p < NumPorts; p++) begin : gen_requesters
    initial begin
      logic [31:0] gap_r, we_r, strb_r, bank_r, row_r, off_r, hi_r, data_r;
      lfsr_q[p] = 16'd72;
      draw_bits(p, 13 * p, data_r);   // Spread the ports along the sequence
      wait (arst_n);
      @(posedge clk);
      // All ports hit bank 0 together, then read a neighbour's row through an alias
      run_access(p, make_req(1'b1, 2'd0, 2'(p), 2'd0, 2'd0, 32'hc0de_0000 + p * 32'h0101, 4'hf));
      dir_done[p] = 1'b1;
      wait (&dir_done);
      @(posedge clk);
      run_access(p, make_req(1'b0, 2'd0, 2'((p + 1) % NumPorts), 2'd3, 2'd1, '0, '0));
      for (int n = 0; n < NumRandom; n++) begin
        draw_bits(p, 2, gap_r);
        draw_bits(p, 1, we_r);
        draw_bits(p, 4, strb_r);
        draw_bits(p, 2, bank_r);
        draw_bits(p, 2, row_r);     // Only 4 rows so reads hit written words
        draw_bits(p, 2, off_r);
        draw_bits(p, 2, hi_r);
        draw_bits(p, 32, data_r);
        repeat (gap_r[1:0]) @(posedge clk);
        run_access(p, make_req(we_r[0], bank_r[1:0], row_r[1:0], off_r[1:0], hi_r[1:0],
                               data_r, strb_r[3:0]));
      end
      port_done[p] = 1'b1;
    end
  end

  function automatic int error_total();
    return u_dut.u_asserts.proto_errs + u_dut.u_asserts.lat_errs + u_dut.u_asserts.data_errs;
  endfunction

  task automatic report_counts();
    $display("Errors: protocol %0d, latency %0d, data %0d after %0d cycles",
             u_dut.u_asserts.proto_errs, u_dut.u_asserts.lat_errs,
             u_dut.u_asserts.data_errs, cycle_cnt);
  endtask

  initial begin : main
    arst_n   = 1'b0;
    req      = '0;
    req_data = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    wait (&port_done);
    repeat (4) @(posedge clk);
    report_counts();
    if (error_total() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: requesters did not finish within %0d cycles", TimeoutCycles);
    report_counts();
    $display("Something failed");
    $finish;
  end

endmodule

// File: testbench/mempool_l2_asserts.sv
/* L2 memory checker, bound to the top level
   Shadow memory with strobe merging plus handshake, latency and read data assertions */

`timescale 1ns/1ps

module mempool_l2_asserts #(
  parameter int unsigned NumPorts = 4
) (
  input logic                                               clk_i,
  input logic                                               arst_n_i,
  input logic                    [NumPorts-1:0]             req_i,
  input mempool_l2_pkg::l2_req_t [NumPorts-1:0]             req_data_i,
  input logic                    [NumPorts-1:0]             ack_i,
  input logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0] rdata_i
);

  int proto_errs = 0;
  int lat_errs   = 0;
  int data_errs  = 0;

  // Shadow of every bank with one written bit per byte
  logic [mempool_l2_pkg::DataWidth-1:0] shadow_q [mempool_l2_pkg::NumL2Banks][256];
  logic [mempool_l2_pkg::StrbWidth-1:0] written_q [mempool_l2_pkg::NumL2Banks][256];

  logic                      [NumPorts-1:0] ack_d_q;
  logic                      [NumPorts-1:0] wr_done;
  logic                      [NumPorts-1:0] bank_shared;   // Another port wants the same bank
  mempool_l2_pkg::bank_idx_t [NumPorts-1:0] bank_of;
  mempool_l2_pkg::row_t      [NumPorts-1:0] row_of;
  logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0] exp_word;
  logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0] exp_mask;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      bank_of[p] = req_data_i[p].addr.fields.bank;
      row_of[p]  = req_data_i[p].addr.fields.row;
      wr_done[p] = ack_i[p] && !ack_d_q[p] && req_data_i[p].we;   // Write commits on ack rise
      exp_word[p] = shadow_q[bank_of[p]][row_of[p]];
      for (int i = 0; i < mempool_l2_pkg::StrbWidth; i++) begin
        exp_mask[p][i*8 +: 8] = {8{written_q[bank_of[p]][row_of[p]][i]}};
      end
    end
    for (int p = 0; p < NumPorts; p++) begin
      bank_shared[p] = 1'b0;
      for (int q = 0; q < NumPorts; q++) begin
        if (q != p && req_i[q] && bank_of[q] == bank_of[p]) begin
          bank_shared[p] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_d_q <= '0;
      for (int b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin
        for (int r = 0; r < 256; r++) begin
          written_q[b][r] <= '0;
        end
      end
    end else begin
      ack_d_q <= ack_i;
      for (int p = 0; p < NumPorts; p++) begin
        if (wr_done[p]) begin
          written_q[bank_of[p]][row_of[p]] <= written_q[bank_of[p]][row_of[p]] |
                                              req_data_i[p].strb;
        end
      end
    end
  end

  // Strobe merge where the newest byte wins
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      for (int i = 0; i < mempool_l2_pkg::StrbWidth; i++) begin
        if (wr_done[p] && req_data_i[p].strb[i]) begin
          shadow_q[bank_of[p]][row_of[p]][i*8 +: 8] <= req_data_i[p].wdata[i*8 +: 8];
        end
      end
    end
  end

  // Reset leaves every ack low
  assert property (@(posedge clk_i) $rose(arst_n_i) |-> ack_i == '0)
    else begin
      proto_errs++;
      $error("ack not low when reset was released");
    end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_checks
    assert property (@(posedge clk_i) disable iff (!arst_n_i) $rose(ack_i[p]) |-> req_i[p])
      else begin
        proto_errs++;
        $error("port %0d ack rose while req was low", p);
      end
    assert property (@(posedge clk_i) disable iff (!arst_n_i) ack_i[p] && req_i[p] |=> ack_i[p])
      else begin
        proto_errs++;
        $error("port %0d ack dropped while req was still high", p);
      end
    assert property (@(posedge clk_i) disable iff (!arst_n_i) ack_i[p] && !req_i[p] |=> !ack_i[p])
      else begin
        proto_errs++;
        $error("port %0d ack did not fall one edge after req went low", p);
      end
    // Idle port keeps ack low
    assert property (@(posedge clk_i) disable iff (!arst_n_i) !ack_i[p] && !req_i[p] |=> !ack_i[p])
      else begin
        proto_errs++;
        $error("port %0d ack rose without a request", p);
      end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     $rose(req_i[p]) |-> !ack_i[p] [*4] ##[1:NumPorts] ack_i[p])
      else begin
        lat_errs++;
        $error("port %0d ack outside the 3 to %0d edge window", p, NumPorts + 2);
      end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     $rose(req_i[p]) && !bank_shared[p] |-> ##4 ack_i[p])
      else begin
        lat_errs++;
        $error("port %0d uncontended access not acked after exactly 3 edges", p);
      end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     $rose(ack_i[p]) && !req_data_i[p].we |->
                     ((rdata_i[p] ^ exp_word[p]) & exp_mask[p]) == '0)
      else begin
        data_errs++;
        $error("[FAIL] rdata_o[%0d] exp %08h got %08h", p,
               $sampled(exp_word[p] & exp_mask[p]), $sampled(rdata_i[p] & exp_mask[p]));
      end
  end

endmodule

bind mempool_l2 mempool_l2_asserts #(
  .NumPorts (NumPorts)
) u_asserts (
  .clk_i      (clk_i     ),
  .arst_n_i   (arst_n_i  ),
  .req_i      (req_i     ),
  .req_data_i (req_data_i),
  .ack_i      (ack_o     ),
  .rdata_i    (rdata_o   )
);

// File: testbench/tb_clkgen.sv
/* Testbench clock generator, 40 ns period */

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o
);

  localparam time HalfPeriod = 20ns;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

endmodule

// File: logic/mempool_l2.sv
/* Banked L2 memory
   Four-phase requester ports, per-bank round-robin crossbar, SRAM banks and response router */

`timescale 1ns/1ps

module mempool_l2 #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic                    [NumPorts-1:0]              req_i,
  input  mempool_l2_pkg::l2_req_t [NumPorts-1:0]              req_data_i,
  output logic                    [NumPorts-1:0]              ack_o,
  output logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0]  rdata_o
);

  // Crossbar to banks
  logic                      [mempool_l2_pkg::NumL2Banks-1:0] bank_valid;
  mempool_l2_pkg::l2_req_t   [mempool_l2_pkg::NumL2Banks-1:0] bank_req;
  mempool_l2_pkg::port_idx_t [mempool_l2_pkg::NumL2Banks-1:0] bank_port;

  // Banks to router
  logic                         [mempool_l2_pkg::NumL2Banks-1:0] bank_rsp_valid;
  mempool_l2_pkg::l2_bank_rsp_t [mempool_l2_pkg::NumL2Banks-1:0] bank_rsp;

  l2_req_xbar #(
    .NumPorts (NumPorts)
  ) i_l2_req_xbar (
    .clk_i        (clk_i     ),
    .arst_n_i     (arst_n_i  ),
    .req_i        (req_i     ),
    .req_data_i   (req_data_i),
    .ack_i        (ack_o     ),   // Closes the issued flag on ack fall
    .bank_valid_o (bank_valid),
    .bank_req_o   (bank_req  ),
    .bank_port_o  (bank_port )
  );

  for (genvar b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin : gen_l2_banks
    l2_bank i_l2_bank (
      .clk_i       (clk_i            ),
      .arst_n_i    (arst_n_i         ),
      .valid_i     (bank_valid[b]    ),
      .req_i       (bank_req[b]      ),
      .port_i      (bank_port[b]     ),
      .rsp_valid_o (bank_rsp_valid[b]),
      .rsp_o       (bank_rsp[b]      )
    );
  end

  l2_rsp_router #(
    .NumPorts (NumPorts)
  ) i_l2_rsp_router (
    .clk_i            (clk_i         ),
    .arst_n_i         (arst_n_i      ),
    .req_i            (req_i         ),
    .bank_rsp_valid_i (bank_rsp_valid),
    .bank_rsp_i       (bank_rsp      ),
    .ack_o            (ack_o         ),
    .rdata_o          (rdata_o       )
  );

endmodule

// File: logic/l2_rsp_router.sv
/* L2 response router
   Steers bank responses by port index into per-port ack and read data registers */

`timescale 1ns/1ps

module l2_rsp_router #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                                        clk_i,
  input  logic                                                        arst_n_i,
  input  logic [NumPorts-1:0]                                         req_i,
  input  logic [mempool_l2_pkg::NumL2Banks-1:0]                       bank_rsp_valid_i,
  input  mempool_l2_pkg::l2_bank_rsp_t [mempool_l2_pkg::NumL2Banks-1:0] bank_rsp_i,
  output logic [NumPorts-1:0]                                         ack_o,
  output logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0]          rdata_o
);

  logic [NumPorts-1:0]                                 rsp_hit;
  logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0]  rsp_data;
  logic [NumPorts-1:0]                                 ack_q;
  logic [NumPorts-1:0][mempool_l2_pkg::DataWidth-1:0]  rdata_q;

  // Match each bank pulse against the port index it carries
  // One access in flight per port, so at most one bank hits a port
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      rsp_hit[p]  = 1'b0;
      rsp_data[p] = '0;
      for (int b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin
        if (bank_rsp_valid_i[b] &&
            (bank_rsp_i[b].port == mempool_l2_pkg::port_idx_t'(p))) begin
          rsp_hit[p]  = 1'b1;
          rsp_data[p] = bank_rsp_i[b].rdata;
        end
      end
    end
  end

  // Ack holds until the port releases its request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (rsp_hit[p]) begin
          ack_q[p] <= 1'b1;
        end else if (!req_i[p]) begin
          ack_q[p] <= 1'b0;   // Four-phase return to idle
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (rsp_hit[p]) begin
        rdata_q[p] <= rsp_data[p];
      end
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

endmodule

// File: logic/l2_bank.sv
/* One L2 bank
   Address-scrambling adapter in front of a byte-enabled single-port SRAM */

`timescale 1ns/1ps

module l2_bank (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          valid_i,
  input  mempool_l2_pkg::l2_req_t       req_i,
  input  mempool_l2_pkg::port_idx_t     port_i,
  output logic                          rsp_valid_o,
  output mempool_l2_pkg::l2_bank_rsp_t  rsp_o
);

  // Adapter to SRAM
  logic                                         sram_req;
  logic                                         sram_we;
  mempool_l2_pkg::row_t                         sram_addr;
  logic [mempool_l2_pkg::DataWidth-1:0]         sram_wdata;
  logic [mempool_l2_pkg::StrbWidth-1:0]         sram_be;
  logic [mempool_l2_pkg::DataWidth-1:0]         sram_rdata_q;

  // Storage
  logic [mempool_l2_pkg::DataWidth-1:0] mem_q [mempool_l2_pkg::L2BankNumWords];

  // Access stage bookkeeping
  logic                      access_valid_q;
  mempool_l2_pkg::port_idx_t access_port_q;

  // Response stage
  logic                         rsp_valid_q;
  mempool_l2_pkg::l2_bank_rsp_t rsp_q;

  // Scrambling keeps only the row, bank and byte bits are cut out
  assign sram_req   = valid_i;
  assign sram_we    = req_i.we;
  assign sram_addr  = req_i.addr.fields.row;
  assign sram_wdata = req_i.wdata;
  assign sram_be    = req_i.strb;

  // Single-port SRAM with one read cycle
  always_ff @(posedge clk_i) begin
    if (sram_req) begin
      if (sram_we) begin
        for (int i = 0; i < mempool_l2_pkg::StrbWidth; i++) begin
          if (sram_be[i]) begin
            mem_q[sram_addr][i*8 +: 8] <= sram_wdata[i*8 +: 8];
          end
        end
      end else begin
        sram_rdata_q <= mem_q[sram_addr];
      end
    end
  end

  // Metadata follows the access through the SRAM cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      access_valid_q <= 1'b0;
    end else begin
      access_valid_q <= sram_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sram_req) begin
      access_port_q <= port_i;
    end
  end

  // Response pulse one cycle after the access, writes included
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= access_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_valid_q) begin
      rsp_q.rdata <= sram_rdata_q;   // Stale for writes, port ignores it
      rsp_q.port  <= access_port_q;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: logic/l2_req_xbar.sv
/* L2 request crossbar
   Round-robin grant of one pending port per bank, payload registered toward the banks */

`timescale 1ns/1ps

module l2_req_xbar #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic                   [NumPorts-1:0]                req_i,
  input  mempool_l2_pkg::l2_req_t [NumPorts-1:0]               req_data_i,
  input  logic                   [NumPorts-1:0]                ack_i,
  output logic                   [mempool_l2_pkg::NumL2Banks-1:0] bank_valid_o,
  output mempool_l2_pkg::l2_req_t [mempool_l2_pkg::NumL2Banks-1:0] bank_req_o,
  output mempool_l2_pkg::port_idx_t [mempool_l2_pkg::NumL2Banks-1:0] bank_port_o
);

  // Per-port state
  logic [NumPorts-1:0] issued_q;   // Request handed to a bank, waiting for the handshake to close
  logic [NumPorts-1:0] ack_q;      // Delayed ack for falling-edge detection
  logic [NumPorts-1:0] eligible;
  logic [NumPorts-1:0] grant_mask;
  mempool_l2_pkg::bank_idx_t [NumPorts-1:0] bank_sel;

  // Per-bank state
  mempool_l2_pkg::port_idx_t [mempool_l2_pkg::NumL2Banks-1:0] rr_q;   // Last granted port
  logic                      [mempool_l2_pkg::NumL2Banks-1:0] grant_valid;
  mempool_l2_pkg::port_idx_t [mempool_l2_pkg::NumL2Banks-1:0] grant_port;

  logic                      [mempool_l2_pkg::NumL2Banks-1:0] bank_valid_q;
  mempool_l2_pkg::l2_req_t   [mempool_l2_pkg::NumL2Banks-1:0] bank_req_q;
  mempool_l2_pkg::port_idx_t [mempool_l2_pkg::NumL2Banks-1:0] bank_port_q;

  assign eligible = req_i & ~issued_q;

  // Bank decode straight from the interleaved address field
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      bank_sel[p] = req_data_i[p].addr.fields.bank;
    end
  end

  // Round-robin search per bank, starting after the last granted port
  always_comb begin : p_grant
    int idx;
    for (int b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin
      grant_valid[b] = 1'b0;
      grant_port[b]  = '0;
      for (int i = 0; i < NumPorts; i++) begin
        idx = int'(rr_q[b]) + 1 + i;
        if (idx >= NumPorts) begin
          idx = idx - NumPorts;   // Wrap once, sum stays below 2*NumPorts
        end
        if (!grant_valid[b] && eligible[idx] &&
            (bank_sel[idx] == mempool_l2_pkg::bank_idx_t'(b))) begin
          grant_valid[b] = 1'b1;
          grant_port[b]  = mempool_l2_pkg::port_idx_t'(idx);
        end
      end
    end
  end

  // A port targets one bank so at most one grant hits it
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      grant_mask[p] = 1'b0;
      for (int b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin
        if (grant_valid[b] && (grant_port[b] == mempool_l2_pkg::port_idx_t'(p))) begin
          grant_mask[p] = 1'b1;
        end
      end
    end
  end

  // Issued flags and ack history
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issued_q <= '0;
      ack_q    <= '0;
    end else begin
      ack_q <= ack_i;
      for (int p = 0; p < NumPorts; p++) begin
        if (grant_mask[p]) begin
          issued_q[p] <= 1'b1;
        end else if (ack_q[p] && !ack_i[p]) begin
          issued_q[p] <= 1'b0;   // Handshake closed
        end
      end
    end
  end

  // Arbitration pointers and bank valids
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q         <= {mempool_l2_pkg::NumL2Banks{mempool_l2_pkg::port_idx_t'(NumPorts - 1)}};
      bank_valid_q <= '0;
    end else begin
      bank_valid_q <= grant_valid;
      for (int b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin
        if (grant_valid[b]) begin
          rr_q[b] <= grant_port[b];
        end
      end
    end
  end

  // Granted payload toward the banks
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin
      if (grant_valid[b]) begin
        bank_req_q[b]  <= req_data_i[grant_port[b]];
        bank_port_q[b] <= grant_port[b];
      end
    end
  end

  assign bank_valid_o = bank_valid_q;
  assign bank_req_o   = bank_req_q;
  assign bank_port_o  = bank_port_q;

endmodule

// File: logic/mempool_l2_pkg.sv
/* L2 memory package
   Geometry constants, the word-interleaved address union and the request and response structs */

package mempool_l2_pkg;

  // Word and address geometry
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Bank organisation
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2SizeBytes    = NumL2Banks * L2BankNumWords * StrbWidth;

  // Address field widths, LSB first: byte offset, bank, row
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);
  localparam int unsigned BankIdxWidth = $clog2(NumL2Banks);
  localparam int unsigned RowWidth     = $clog2(L2BankNumWords);
  localparam int unsigned UnusedWidth  = AddrWidth - RowWidth - BankIdxWidth - ByteOffWidth;

  // Enough for up to 8 requester ports
  localparam int unsigned MaxPortIdxWidth = 3;

  typedef logic [BankIdxWidth-1:0]    bank_idx_t;
  typedef logic [RowWidth-1:0]        row_t;
  typedef logic [MaxPortIdxWidth-1:0] port_idx_t;

  // Upper bits are ignored so the L2 aliases every L2SizeBytes
  typedef struct packed {
    logic [UnusedWidth-1:0]  unused;
    row_t                    row;      // Word row inside the bank
    bank_idx_t               bank;     // Word-interleaved bank select
    logic [ByteOffWidth-1:0] byte_off;
  } l2_addr_fields_t;

  // Same address word, seen raw or split into fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    l2_addr_fields_t      fields;
  } l2_addr_u;

  typedef struct packed {
    l2_addr_u             addr;
    logic                 we;     // 1 for write
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } l2_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    port_idx_t            port;   // Requester that gets this response
  } l2_bank_rsp_t;

endpackage
